// File: common/adp_defs.svh
/*
 * Bus-to-SRAM adapter widths, FIFO depth and the blanking word
 */
`ifndef ADP_DEFS_SVH
`define ADP_DEFS_SVH

// Bus word is 32 bits wide, 4 byte lanes
`define ADP_BUS_DW 32
`define ADP_BUS_BW 4

// SRAM word holds two bus words
`define ADP_SRAM_DW 64
`define ADP_LANES 2
`define ADP_SRAM_AW 10

// Byte address: 10 word bits, 1 lane bit, 2 byte bits
`define ADP_BUS_AW 13

// Request attributes carried back on the response
`define ADP_SRC_W 4
`define ADP_SIZE_W 2

// Max requests in flight, also every FIFO depth
`define ADP_OUTSTANDING 2

// Returned on writes and on every error response
`define ADP_ERR_DATA 32'hDEAD_C0DE

`endif

// File: common/adp_pkg.sv
/*
 * Shared types of the bus-to-SRAM adapter: bus opcodes and FIFO entries
 */
`include "adp_defs.svh"

package adp_pkg;

  // A-channel opcodes, every other value is rejected
  typedef enum logic [2:0] {
    op_put_full    = 3'd0,
    op_put_partial = 3'd1,
    op_get         = 3'd4
  } adp_op_e;

  // D-channel opcodes
  typedef enum logic [2:0] {
    d_access_ack      = 3'd0,
    d_access_ack_data = 3'd1
  } adp_d_op_e;

  // What the response has to look like
  typedef enum logic {
    kind_write = 1'b0,
    kind_read  = 1'b1
  } adp_kind_e;

  // One entry per accepted request, popped when the response leaves
  typedef struct packed {
    adp_kind_e               kind;
    logic                    err;
    logic [`ADP_SIZE_W-1:0]  size;
    logic [`ADP_SRC_W-1:0]   source;
  } adp_req_t;

  // One entry per granted read, popped when rvalid returns
  typedef struct packed {
    logic [`ADP_BUS_BW-1:0]          mask;
    logic [$clog2(`ADP_LANES)-1:0]   lane;
  } adp_lane_t;

  // Read word already lane selected and masked
  typedef struct packed {
    logic [`ADP_BUS_DW-1:0]  data;
    logic                    err;
  } adp_rsp_t;

endpackage

// File: common/adp_fifo_if.sv
/*
 * Push/pop handshake of one adapter FIFO, payload type set per instance
 */
`timescale 1ns/1ps

interface adp_fifo_if #(
  parameter type adp_payload_t = logic
);

  // Push side, transfer on valid and ready
  logic          push_valid;
  logic          push_ready;
  adp_payload_t  push_data;

  // Pop side, transfer on valid and ready
  logic          pop_valid;
  logic          pop_ready;
  adp_payload_t  pop_data;

  modport producer (
    output push_valid, push_data,
    input  push_ready
  );

  modport fifo (
    input  push_valid, push_data, pop_ready,
    output push_ready, pop_valid, pop_data
  );

  modport consumer (
    input  pop_valid, pop_data,
    output pop_ready
  );

endinterface

// File: hdl/adp_fifo.sv
/*
 * Synchronous FIFO for adapter bookkeeping, depth set by the outstanding limit
 */
`timescale 1ns/1ps
`include "adp_defs.svh"

module adp_fifo #(
  parameter type adp_payload_t = logic
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  adp_fifo_if.fifo  q
);

  localparam int Depth = `ADP_OUTSTANDING;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = $clog2(Depth + 1);

  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [CntW-1:0]  count_q;
  logic             push;
  logic             pop;
  adp_payload_t     mem_q [Depth];

  // Room and data flags straight from the count
  assign q.push_ready = (count_q != CntW'(Depth));
  assign q.pop_valid  = (count_q != '0);
  // Head entry, only written data reaches it so no bypass
  assign q.pop_data   = mem_q[rd_ptr_q];

  assign push = q.push_valid & q.push_ready;
  assign pop  = q.pop_valid & q.pop_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // Wrap at depth, depth need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push != pop) begin
        count_q <= push ? count_q + 1'b1 : count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= q.push_data;
    end
  end

  // Producer never offers data that would be dropped
  push_when_full_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    q.push_valid |-> q.push_ready);

  // Consumer only takes what is there
  pop_when_empty_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    q.pop_ready |-> q.pop_valid);

endmodule

// File: sram_adapter/adp_req_check.sv
/*
 * Request side of the adapter: request checking, SRAM request build and
 * bookkeeping pushes for the response side
 */
`timescale 1ns/1ps
`include "adp_defs.svh"

module adp_req_check (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     a_valid_i,
  input  logic [2:0]               a_opcode_i,
  input  logic [`ADP_BUS_AW-1:0]   a_address_i,
  input  logic [`ADP_BUS_BW-1:0]   a_mask_i,
  input  logic [`ADP_BUS_DW-1:0]   a_data_i,
  input  logic [`ADP_SIZE_W-1:0]   a_size_i,
  input  logic [`ADP_SRC_W-1:0]    a_source_i,
  output logic                     a_ready_o,
  input  logic                     gnt_i,
  output logic                     req_o,
  output logic                     we_o,
  output logic [`ADP_SRAM_AW-1:0]  addr_o,
  output logic [`ADP_SRAM_DW-1:0]  wdata_o,
  output logic [`ADP_SRAM_DW-1:0]  wmask_o,
  adp_fifo_if.producer             req_q,
  adp_fifo_if.producer             lane_q
);

  localparam int ByteOffW = $clog2(`ADP_BUS_BW);
  localparam int LaneW    = $clog2(`ADP_LANES);

  logic                                     is_read;
  logic                                     is_write;
  logic                                     req_err;
  logic                                     room;
  logic                                     missed_gnt_q;
  logic [LaneW-1:0]                         lane;
  logic [`ADP_LANES-1:0][`ADP_BUS_DW-1:0]   wdata_lanes;
  logic [`ADP_LANES-1:0][`ADP_BUS_DW-1:0]   wmask_lanes;
  adp_pkg::adp_req_t                        req_entry;

  // Only the three supported opcodes are legal
  assign is_read  = (a_opcode_i == adp_pkg::op_get);
  assign is_write = (a_opcode_i == adp_pkg::op_put_full) |
                    (a_opcode_i == adp_pkg::op_put_partial);
  // Bad opcode or empty mask gets an error reply, no SRAM access
  assign req_err  = ~(is_read | is_write) | (a_mask_i == '0);

  // Both bookkeeping FIFOs must take the entry
  assign room = req_q.push_ready & lane_q.push_ready;

  assign req_o     = a_valid_i & ~req_err & room;
  // Error requests see no grant, so ready is forced one cycle later
  assign a_ready_o = (gnt_i | missed_gnt_q) & room;
  assign we_o      = a_valid_i & is_write;

  // Word bits above the lane and byte offset
  assign addr_o = a_address_i[ByteOffW+LaneW +: `ADP_SRAM_AW];
  assign lane   = a_address_i[ByteOffW +: LaneW];

  // Byte mask expanded to bits, placed in the addressed lane
  always_comb begin
    wdata_lanes = '0;
    wmask_lanes = '0;
    for (int i = 0; i < `ADP_BUS_BW; i++) begin
      wmask_lanes[lane][8*i +: 8] = {8{a_mask_i[i]}};
      // Reads drive zero data
      wdata_lanes[lane][8*i +: 8] = (a_mask_i[i] && is_write) ? a_data_i[8*i +: 8] : 8'h00;
    end
  end

  assign wdata_o = wdata_lanes;
  assign wmask_o = wmask_lanes;

  always_comb begin
    req_entry.kind   = is_read ? adp_pkg::kind_read : adp_pkg::kind_write;
    req_entry.err    = req_err;
    req_entry.size   = a_size_i;
    req_entry.source = a_source_i;
  end

  // Every accepted request gets a response slot
  assign req_q.push_valid = a_valid_i & a_ready_o;
  assign req_q.push_data  = req_entry;

  // Lane info only for reads that really went to the SRAM
  assign lane_q.push_valid     = req_o & gnt_i & is_read;
  assign lane_q.push_data.mask = a_mask_i;
  assign lane_q.push_data.lane = lane;

  // Error request seen but not accepted this cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      missed_gnt_q <= 1'b0;
    end else begin
      missed_gnt_q <= a_valid_i & req_err & ~a_ready_o;
    end
  end

  // A stalled SRAM request stays up with the same word address
  req_held_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o && !gnt_i |=> req_o && $stable(addr_o));

endmodule

// File: sram_adapter/adp_rsp_assemble.sv
/*
 * Response side of the adapter: read lane extraction, read data buffering,
 * in-order D-channel responses and the sticky fault flag
 */
`timescale 1ns/1ps
`include "adp_defs.svh"

module adp_rsp_assemble (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rvalid_i,
  input  logic [`ADP_SRAM_DW-1:0]  rdata_i,
  input  logic                     rerror_i,
  output logic                     d_valid_o,
  input  logic                     d_ready_i,
  output logic [2:0]               d_opcode_o,
  output logic [`ADP_SIZE_W-1:0]   d_size_o,
  output logic [`ADP_SRC_W-1:0]    d_source_o,
  output logic [`ADP_BUS_DW-1:0]   d_data_o,
  output logic                     d_error_o,
  output logic                     fault_o,
  adp_fifo_if.consumer             req_q,
  adp_fifo_if.consumer             lane_q,
  adp_fifo_if.producer             rsp_push,
  adp_fifo_if.consumer             rsp_pop
);

  logic [`ADP_LANES-1:0][`ADP_BUS_DW-1:0]  rdata_lanes;
  logic [`ADP_BUS_DW-1:0]                  rmask;
  logic                                    rd_match;
  logic                                    head_rd;
  logic                                    head_is_get;
  logic                                    d_ack;
  logic                                    fault_q;

  // SRAM word viewed as bus lanes
  assign rdata_lanes = rdata_i;

  // Returning read pairs with the oldest lane entry
  assign rd_match         = rvalid_i & lane_q.pop_valid;
  assign lane_q.pop_ready = rd_match;

  always_comb begin
    for (int i = 0; i < `ADP_BUS_BW; i++) begin
      rmask[8*i +: 8] = {8{lane_q.pop_data.mask[i]}};
    end
  end

  // Unrequested bytes are zeroed before buffering
  assign rsp_push.push_valid     = rd_match;
  assign rsp_push.push_data.data = rdata_lanes[lane_q.pop_data.lane] & rmask;
  assign rsp_push.push_data.err  = rerror_i;

  // Head request decides what the response waits for
  assign head_is_get = (req_q.pop_data.kind == adp_pkg::kind_read);
  // Rejected reads never reached the SRAM
  assign head_rd     = head_is_get & ~req_q.pop_data.err;

  // Writes and errors answer at once, reads wait for data
  assign d_valid_o = req_q.pop_valid & (~head_rd | rsp_pop.pop_valid);
  assign d_error_o = d_valid_o & (req_q.pop_data.err |
                                  (head_rd & rsp_pop.pop_data.err));

  assign d_opcode_o = (d_valid_o && head_is_get) ? adp_pkg::d_access_ack_data :
                                                   adp_pkg::d_access_ack;
  assign d_size_o   = d_valid_o ? req_q.pop_data.size : '0;
  assign d_source_o = d_valid_o ? req_q.pop_data.source : '0;
  // Blanking word unless this is a clean read
  assign d_data_o   = (d_valid_o && head_rd && !d_error_o) ? rsp_pop.pop_data.data :
                                                             `ADP_ERR_DATA;

  // Both entries leave together on the D handshake
  assign d_ack             = d_valid_o & d_ready_i;
  assign req_q.pop_ready   = d_ack;
  assign rsp_pop.pop_ready = d_ack & head_rd;

  // Read data with nothing in flight, kept until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_q <= 1'b0;
    end else if (rvalid_i && !lane_q.pop_valid) begin
      fault_q <= 1'b1;
    end
  end

  assign fault_o = fault_q;

  // SRAM has no back-pressure, rsp_q depth must cover every read in flight
  rvalid_room_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> rsp_push.push_ready);

endmodule

// File: sram_adapter/sram_adapter.sv
/*
 * Bus-to-SRAM adapter top: single-beat bus requests onto a 64-bit SRAM,
 * in-order responses, up to two requests outstanding
 */
`timescale 1ns/1ps
`include "adp_defs.svh"

module sram_adapter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Request channel
  input  logic                     a_valid_i,
  output logic                     a_ready_o,
  input  logic [2:0]               a_opcode_i,
  input  logic [`ADP_BUS_AW-1:0]   a_address_i,
  input  logic [`ADP_BUS_BW-1:0]   a_mask_i,
  input  logic [`ADP_BUS_DW-1:0]   a_data_i,
  input  logic [`ADP_SIZE_W-1:0]   a_size_i,
  input  logic [`ADP_SRC_W-1:0]    a_source_i,
  // Response channel
  output logic                     d_valid_o,
  input  logic                     d_ready_i,
  output logic [2:0]               d_opcode_o,
  output logic [`ADP_SIZE_W-1:0]   d_size_o,
  output logic [`ADP_SRC_W-1:0]    d_source_o,
  output logic [`ADP_BUS_DW-1:0]   d_data_o,
  output logic                     d_error_o,
  // SRAM port
  output logic                     req_o,
  input  logic                     gnt_i,
  output logic                     we_o,
  output logic [`ADP_SRAM_AW-1:0]  addr_o,
  output logic [`ADP_SRAM_DW-1:0]  wdata_o,
  output logic [`ADP_SRAM_DW-1:0]  wmask_o,
  input  logic                     rvalid_i,
  input  logic [`ADP_SRAM_DW-1:0]  rdata_i,
  input  logic                     rerror_i,
  output logic                     fault_o
);

  // Request order, read lane info and buffered read data
  adp_fifo_if #(.adp_payload_t(adp_pkg::adp_req_t))  req_q ();
  adp_fifo_if #(.adp_payload_t(adp_pkg::adp_lane_t)) lane_q ();
  adp_fifo_if #(.adp_payload_t(adp_pkg::adp_rsp_t))  rsp_q ();

  adp_fifo #(.adp_payload_t(adp_pkg::adp_req_t)) u_req_fifo (
    .clk_i, .rst_ni, .q(req_q)
  );

  adp_fifo #(.adp_payload_t(adp_pkg::adp_lane_t)) u_lane_fifo (
    .clk_i, .rst_ni, .q(lane_q)
  );

  adp_fifo #(.adp_payload_t(adp_pkg::adp_rsp_t)) u_rsp_fifo (
    .clk_i, .rst_ni, .q(rsp_q)
  );

  adp_req_check u_req_check (
    .clk_i, .rst_ni,
    .a_valid_i, .a_opcode_i, .a_address_i, .a_mask_i, .a_data_i, .a_size_i, .a_source_i,
    .a_ready_o, .gnt_i,
    .req_o, .we_o, .addr_o, .wdata_o, .wmask_o,
    .req_q (req_q),
    .lane_q(lane_q)
  );

  // rsp_q is filled and drained by the same block
  adp_rsp_assemble u_rsp_assemble (
    .clk_i, .rst_ni,
    .rvalid_i, .rdata_i, .rerror_i,
    .d_valid_o, .d_ready_i, .d_opcode_o, .d_size_o, .d_source_o, .d_data_o, .d_error_o,
    .fault_o,
    .req_q   (req_q),
    .lane_q  (lane_q),
    .rsp_push(rsp_q),
    .rsp_pop (rsp_q)
  );

endmodule

// File: test/tb_sram_model.sv
/*
 * Behavioural SRAM for the adapter testbench: random grant stalls,
 * one-cycle read latency and one word that reports a read error
 */
`timescale 1ns/1ps
`include "adp_defs.svh"

module tb_sram_model #(
  parameter logic [`ADP_SRAM_AW-1:0] ErrWord = '0
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     stall_i,
  input  logic                     spurious_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [`ADP_SRAM_AW-1:0]  addr_i,
  input  logic [`ADP_SRAM_DW-1:0]  wdata_i,
  input  logic [`ADP_SRAM_DW-1:0]  wmask_i,
  output logic                     gnt_o,
  output logic                     rvalid_o,
  output logic [`ADP_SRAM_DW-1:0]  rdata_o,
  output logic                     rerror_o
);

  localparam int Words = 1 << `ADP_SRAM_AW;

  logic [`ADP_SRAM_DW-1:0]  mem [Words];
  logic                     rd_go;

  // Power-up content, every byte set from its own full byte address
  function automatic logic [7:0] fill_byte(input logic [`ADP_BUS_AW-1:0] b);
    return 8'(b ^ (b >> 5));
  endfunction

  initial begin
    for (int w = 0; w < Words; w++) begin
      for (int k = 0; k < 8; k++) begin
        mem[w][8*k +: 8] = fill_byte(`ADP_BUS_AW'(w * 8 + k));
      end
    end
  end

  // Grant follows request unless the stall input says otherwise
  assign gnt_o = req_i & ~stall_i;
  assign rd_go = req_i & gnt_o & ~we_i;

  // Bit-masked write
  always @(posedge clk_i) begin
    if (req_i && gnt_o && we_i) begin
      mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  // Read data one cycle after grant; spurious pulse fakes a return
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
      rerror_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= rd_go | spurious_i;
      rerror_o <= rd_go & (addr_i == ErrWord);
      if (rd_go) begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// File: test/tb_sram_adapter.sv
/*
 * Testbench of the bus-to-SRAM adapter: table-driven requests checked
 * against a byte-level reference memory, with random grant and D stalls
 */
`timescale 1ns/1ps
`include "adp_defs.svh"

module tb_sram_adapter;

  localparam int NumRows       = 16;
  localparam int TimeoutCycles = NumRows * 40;
  // Reads of this SRAM word come back with rerror set
  localparam logic [`ADP_SRAM_AW-1:0] ErrWord = 10'h020;

  // One request per row
  typedef struct packed {
    logic [2:0]              op;
    logic [`ADP_BUS_AW-1:0]  addr;
    logic [`ADP_BUS_BW-1:0]  mask;
    logic [`ADP_BUS_DW-1:0]  data;
    logic [`ADP_SIZE_W-1:0]  size;
    logic [`ADP_SRC_W-1:0]   src;
  } stim_t;

  // What the D channel must show for an accepted request
  typedef struct packed {
    logic [7:0]              row;
    logic [2:0]              op;
    logic [`ADP_BUS_DW-1:0]  data;
    logic                    err;
    logic [`ADP_SIZE_W-1:0]  size;
    logic [`ADP_SRC_W-1:0]   src;
  } exp_t;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     a_valid_i;
  logic                     a_ready_o;
  logic [2:0]               a_opcode_i;
  logic [`ADP_BUS_AW-1:0]   a_address_i;
  logic [`ADP_BUS_BW-1:0]   a_mask_i;
  logic [`ADP_BUS_DW-1:0]   a_data_i;
  logic [`ADP_SIZE_W-1:0]   a_size_i;
  logic [`ADP_SRC_W-1:0]    a_source_i;
  logic                     d_valid_o;
  logic                     d_ready_i;
  logic [2:0]               d_opcode_o;
  logic [`ADP_SIZE_W-1:0]   d_size_o;
  logic [`ADP_SRC_W-1:0]    d_source_o;
  logic [`ADP_BUS_DW-1:0]   d_data_o;
  logic                     d_error_o;
  logic                     req_o;
  logic                     gnt_i;
  logic                     we_o;
  logic [`ADP_SRAM_AW-1:0]  addr_o;
  logic [`ADP_SRAM_DW-1:0]  wdata_o;
  logic [`ADP_SRAM_DW-1:0]  wmask_o;
  logic                     rvalid_i;
  logic [`ADP_SRAM_DW-1:0]  rdata_i;
  logic                     rerror_i;
  logic                     fault_o;
  logic                     stall;
  logic                     spurious;

  stim_t       stim [NumRows];
  exp_t        exp_q [$];
  logic [7:0]  ref_mem [1 << `ADP_BUS_AW];
  bit          req_seen [NumRows];
  int          seed = 59812;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          resp_count;
  int          cycles;

  sram_adapter u_sram_adapter (
    .clk_i, .rst_ni,
    .a_valid_i, .a_ready_o, .a_opcode_i, .a_address_i, .a_mask_i, .a_data_i,
    .a_size_i, .a_source_i,
    .d_valid_o, .d_ready_i, .d_opcode_o, .d_size_o, .d_source_o, .d_data_o, .d_error_o,
    .req_o, .gnt_i, .we_o, .addr_o, .wdata_o, .wmask_o,
    .rvalid_i, .rdata_i, .rerror_i,
    .fault_o
  );

  tb_sram_model #(.ErrWord(ErrWord)) u_sram_model (
    .clk_i, .rst_ni,
    .stall_i   (stall),
    .spurious_i(spurious),
    .req_i     (req_o),
    .we_i      (we_o),
    .addr_i    (addr_o),
    .wdata_i   (wdata_o),
    .wmask_i   (wmask_o),
    .gnt_o     (gnt_i),
    .rvalid_o  (rvalid_i),
    .rdata_o   (rdata_i),
    .rerror_o  (rerror_i)
  );

  // Same power-up content as the SRAM model, per byte address
  function automatic logic [7:0] fill_byte(input logic [`ADP_BUS_AW-1:0] b);
    return 8'(b ^ (b >> 5));
  endfunction

  // op, byte address, mask, data, size, source
  task automatic load_table();
    stim[0]  = '{3'd0, 13'h0040, 4'hF, 32'h1122_3344, 2'd2, 4'd1};
    stim[1]  = '{3'd0, 13'h0044, 4'hF, 32'h5566_7788, 2'd2, 4'd2};
    stim[2]  = '{3'd4, 13'h0040, 4'hF, 32'h0, 2'd2, 4'd3};
    stim[3]  = '{3'd4, 13'h0044, 4'hF, 32'h0, 2'd2, 4'd4};
    stim[4]  = '{3'd1, 13'h0048, 4'b0101, 32'hAABB_CCDD, 2'd1, 4'd5};
    stim[5]  = '{3'd4, 13'h0048, 4'hF, 32'h0, 2'd2, 4'd6};
    stim[6]  = '{3'd4, 13'h0048, 4'b0110, 32'h0, 2'd1, 4'd7};
    // Illegal opcode, then zero masks on a write and a read
    stim[7]  = '{3'd2, 13'h0050, 4'hF, 32'h0BAD_0BAD, 2'd2, 4'd8};
    stim[8]  = '{3'd0, 13'h0054, 4'h0, 32'h1234_5678, 2'd2, 4'd9};
    stim[9]  = '{3'd4, 13'h0040, 4'h0, 32'h0, 2'd2, 4'd10};
    // Lands on the word with a read error
    stim[10] = '{3'd4, 13'h0104, 4'hF, 32'h0, 2'd2, 4'd11};
    stim[11] = '{3'd1, 13'h1F4C, 4'b1100, 32'hCAFE_F00D, 2'd1, 4'd12};
    stim[12] = '{3'd4, 13'h1F4C, 4'hF, 32'h0, 2'd2, 4'd13};
    stim[13] = '{3'd7, 13'h1F4C, 4'hF, 32'h0, 2'd2, 4'd14};
    stim[14] = '{3'd4, 13'h1F48, 4'b0011, 32'h0, 2'd1, 4'd15};
    stim[15] = '{3'd4, 13'h0A10, 4'hF, 32'h0, 2'd2, 4'd0};
  endtask

  task automatic report_fail(input string msg);
    $display("[FAIL] time %0d ns: %s", $time, msg);
    errors++;
  endtask

  function automatic logic is_rejected(input stim_t s);
    return !(s.op == 3'd0 || s.op == 3'd1 || s.op == 3'd4) || s.mask == '0;
  endfunction

  // Reference model: expected response and reference memory update
  task automatic record_expected(input int row);
    stim_t                   s;
    exp_t                    e;
    logic                    bad;
    logic                    is_get;
    logic [`ADP_BUS_AW-1:0]  idx;
    s      = stim[row];
    bad    = is_rejected(s);
    is_get = (s.op == 3'd4);
    e.row  = 8'(row);
    e.op   = is_get ? 3'd1 : 3'd0;
    e.err  = bad | (is_get & (s.addr[`ADP_BUS_AW-1:3] == ErrWord));
    e.size = s.size;
    e.src  = s.src;
    e.data = `ADP_ERR_DATA;
    if (is_get && !e.err) begin
      e.data = '0;
    end
    for (int b = 0; b < `ADP_BUS_BW; b++) begin
      idx = {s.addr[`ADP_BUS_AW-1:2], 2'(b)};
      if (is_get && !e.err && s.mask[b]) begin
        e.data[8*b +: 8] = ref_mem[idx];
      end
      if (!bad && !is_get && s.mask[b]) begin
        ref_mem[idx] = s.data[8*b +: 8];
      end
    end
    exp_q.push_back(e);
  endtask

  // Drive one row, hold it until accepted
  task automatic send_request(input int row);
    stim_t  s;
    logic   accepted;
    s           = stim[row];
    a_valid_i   = 1'b1;
    a_opcode_i  = s.op;
    a_address_i = s.addr;
    a_mask_i    = s.mask;
    a_data_i    = s.data;
    a_size_i    = s.size;
    a_source_i  = s.src;
    accepted    = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      // Rejected requests must stay off the SRAM port
      if (is_rejected(s) && req_o && !req_seen[row]) begin
        req_seen[row] = 1'b1;
        report_fail($sformatf("req_o raised for rejected request of test %0d", row));
      end
      accepted = a_ready_o;
    end
    record_expected(row);
    @(posedge clk_i);
    #2;
    a_valid_i = 1'b0;
  endtask

  // Compare the response taken at the coming edge with the oldest expected
  task automatic check_response();
    exp_t  e;
    int    bad;
    if (exp_q.size() == 0) begin
      report_fail($sformatf("response with nothing outstanding, source %0d", d_source_o));
      tests_failed++;
    end else begin
      e   = exp_q.pop_front();
      bad = req_seen[e.row] ? 1 : 0;
      if (d_source_o !== e.src) begin
        report_fail($sformatf("source %0d, expected %0d", d_source_o, e.src));
        bad++;
      end
      if (d_size_o !== e.size) begin
        report_fail($sformatf("size %0d, expected %0d", d_size_o, e.size));
        bad++;
      end
      if (d_opcode_o !== e.op) begin
        report_fail($sformatf("opcode %0d, expected %0d", d_opcode_o, e.op));
        bad++;
      end
      if (d_error_o !== e.err) begin
        report_fail($sformatf("error %0b, expected %0b", d_error_o, e.err));
        bad++;
      end
      if (d_data_o !== e.data) begin
        report_fail($sformatf("data %h, expected %h", d_data_o, e.data));
        bad++;
      end
      if (bad == 0) begin
        tests_passed++;
        $display("test %0d source %0d: pass", e.row, e.src);
      end else begin
        tests_failed++;
        $display("test %0d source %0d: fail", e.row, e.src);
      end
    end
    resp_count++;
  endtask

  // Read data with no read in flight must set the sticky fault
  task automatic check_spurious_fault();
    int  errs_before;
    errs_before = errors;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    if (fault_o !== 1'b0) begin
      report_fail("fault_o high before any spurious read data");
    end
    @(posedge clk_i);
    #2 spurious = 1'b1;
    @(posedge clk_i);
    #2 spurious = 1'b0;
    // Model rvalid rose at the last edge, the fault latches one edge later
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    if (fault_o !== 1'b1) begin
      report_fail("fault_o not set after spurious rvalid");
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    if (fault_o !== 1'b1) begin
      report_fail("fault_o did not stay high");
    end
    if (errors == errs_before) begin
      tests_passed++;
      $display("test spurious rvalid: pass");
    end else begin
      tests_failed++;
      $display("test spurious rvalid: fail");
    end
  endtask

  task automatic check_reset_state();
    if (a_ready_o !== 1'b0 || req_o !== 1'b0 || d_valid_o !== 1'b0 || fault_o !== 1'b0) begin
      report_fail("outputs not low in reset");
      tests_failed++;
      $display("test reset state: fail");
    end else begin
      tests_passed++;
      $display("test reset state: pass");
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Random grant stalls and D-channel back-pressure
  initial begin
    stall     = 1'b0;
    d_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      stall     = (($random(seed) & 3) == 0);
      d_ready_i = (($random(seed) & 3) != 0);
    end
  end

  // Run limit from the table length
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TimeoutCycles) begin
        $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
        $display("ERRORS FOUND");
        $finish;
      end
    end
  end

  // D handshake completes at the next rising edge
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni && d_valid_o && d_ready_i) begin
        check_response();
      end
    end
  end

  initial begin
    rst_ni      = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = '0;
    a_address_i = '0;
    a_mask_i    = '0;
    a_data_i    = '0;
    a_size_i    = '0;
    a_source_i  = '0;
    spurious    = 1'b0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    resp_count   = 0;
    load_table();
    for (int b = 0; b < (1 << `ADP_BUS_AW); b++) begin
      ref_mem[b] = fill_byte(`ADP_BUS_AW'(b));
    end
    // Reset held for four rising edges
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_reset_state();
    @(posedge clk_i);
    #2 rst_ni = 1'b1;
    for (int i = 0; i < NumRows; i++) begin
      send_request(i);
    end
    while (resp_count < NumRows) begin
      @(posedge clk_i);
    end
    check_spurious_fault();
    $display("Tests passed: %0d, tests failed: %0d, failed checks: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && exp_q.size() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+common
common/adp_pkg.sv
common/adp_fifo_if.sv
hdl/adp_fifo.sv
sram_adapter/adp_req_check.sv
sram_adapter/adp_rsp_assemble.sv
sram_adapter/sram_adapter.sv
test/tb_sram_model.sv
test/tb_sram_adapter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the adapter testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  -f sim.f \
  --top-module tb_sram_adapter \
  -o vsim

# Simulation status is taken from the log below
./obj_dir/vsim | tee sim.log || true

if grep -qx "NO ERRORS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
